/* iq_pkg.sv */
// Shared types for the instruction queue
// Instruction word, PC and fetch exception code vectors

package iq_pkg;

   // Field widths of one queue entry
   localparam int INSN_W = 32;
   localparam int PC_W   = 32;
   localparam int EXC_W  = 2;

   // One instruction word
   typedef logic [INSN_W-1:0] insn_t;

   // Instruction address
   typedef logic [PC_W-1:0]   pc_t;

   // Fetch exception code, zero when clean
   typedef logic [EXC_W-1:0]  exc_t;

endpackage

/* fifo_fwft.sv */
// First-word-fall-through FIFO used as one instruction queue bank
// Circular buffer with occupancy count, flush clears pointers

`timescale 1ns/1ps

module fifo_fwft
#(
   parameter int DW          = 66,
   parameter int DEPTH_WIDTH = 2
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          flush,
   input  logic          push,
   input  logic [DW-1:0] din,
   output logic          ready,
   input  logic          pop,
   output logic [DW-1:0] dout,
   output logic          valid
);

   localparam int DEPTH = 1 << DEPTH_WIDTH;

   // Storage, no reset
   logic [DW-1:0]          mem [DEPTH];
   logic [DEPTH_WIDTH-1:0] rptr;
   logic [DEPTH_WIDTH-1:0] wptr;
   logic [DEPTH_WIDTH:0]   count;
   logic                   do_push;
   logic                   do_pop;

   // Full exactly when the count MSB is set
   assign ready = ~count[DEPTH_WIDTH];
   assign valid = |count;

   // Head entry falls through to the output
   assign dout = mem[rptr];

   // Qualified strobes
   assign do_push = push & ready;
   assign do_pop  = pop & valid;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wptr] <= din;
   end

   // Pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
            wptr <= wptr + 1'b1;
         if (do_pop)
            rptr <= rptr + 1'b1;
         // Simultaneous push and pop keeps the count
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* iq.sv */
// Banked instruction queue
// One FWFT bank per fetch slot, rotating head and tail bank pointers
// Input steering from the fetch window, output steering to the issue slots

`timescale 1ns/1ps

module iq
   import iq_pkg::*;
#(
   parameter int P_FETCH_WIDTH = 2,
   parameter int P_ISSUE_WIDTH = 1,
   parameter int P_IQ_DEPTH    = 2
)
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              flush,
   // Fetch window, entries packed at the high slots
   input  insn_t [(1<<P_FETCH_WIDTH)-1:0]    fetch_ins,
   input  pc_t   [(1<<P_FETCH_WIDTH)-1:0]    fetch_pc,
   input  exc_t  [(1<<P_FETCH_WIDTH)-1:0]    fetch_exc,
   input  logic  [P_FETCH_WIDTH:0]           fetch_cnt,
   output logic                              fetch_ready,
   // Issue slots toward the decode latch
   output logic  [(1<<P_ISSUE_WIDTH)-1:0]    iq_valid,
   input  logic  [P_ISSUE_WIDTH:0]           iq_pop_cnt,
   output insn_t [(1<<P_ISSUE_WIDTH)-1:0]    iq_ins,
   output pc_t   [(1<<P_ISSUE_WIDTH)-1:0]    iq_pc,
   output exc_t  [(1<<P_ISSUE_WIDTH)-1:0]    iq_exc
);

   localparam int FW      = 1 << P_FETCH_WIDTH;
   localparam int IW      = 1 << P_ISSUE_WIDTH;
   localparam int P_BANKS = P_FETCH_WIDTH;
   localparam int BANKS   = FW;
   // Instruction, PC and exception code per entry
   localparam int ENTRY_W = INSN_W + PC_W + EXC_W;

   // Bank pointers
   logic [P_BANKS-1:0] head;
   logic [P_BANKS-1:0] tail;
   logic [P_BANKS-1:0] head_nxt;
   logic [P_BANKS-1:0] tail_nxt;
   // Slot of the oldest window entry
   logic [P_BANKS-1:0] win_ofs;

   logic [ENTRY_W-1:0] bank_din  [BANKS];
   logic [ENTRY_W-1:0] bank_dout [BANKS];
   logic [BANKS-1:0]   bank_push;
   logic [BANKS-1:0]   bank_pop;
   logic [BANKS-1:0]   bank_ready;
   logic [BANKS-1:0]   bank_valid;

   // Empty slots sit below the packed entries
   assign win_ofs = P_BANKS'(FW - fetch_cnt);

   // Rotation by the push and pop counts, wraps over the banks
   assign head_nxt = head + P_BANKS'(iq_pop_cnt);
   assign tail_nxt = tail + P_BANKS'(fetch_cnt);

   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         head <= head_nxt;
         tail <= tail_nxt;
      end
   end

   // Per-bank steering and storage
   for (genvar i = 0; i < BANKS; i++)
   begin : g_bank
      logic [P_BANKS-1:0] tail_dist;
      logic [P_BANKS-1:0] head_dist;
      logic [P_BANKS-1:0] slot_sel;

      // Distance of this bank from each pointer
      assign tail_dist = P_BANKS'(i) - tail;
      assign head_dist = P_BANKS'(i) - head;
      // Window slot this bank takes
      assign slot_sel  = tail_dist + win_ofs;

      assign bank_push[i] = ({1'b0, tail_dist} < fetch_cnt);
      assign bank_pop[i]  = ({1'b0, head_dist} < (P_BANKS+1)'(iq_pop_cnt));
      assign bank_din[i]  = {fetch_ins[slot_sel], fetch_pc[slot_sel], fetch_exc[slot_sel]};

      fifo_fwft
      #(
         .DW          (ENTRY_W),
         .DEPTH_WIDTH (P_IQ_DEPTH)
      )
      i_fifo
      (
         .clk   (clk),
         .reset (reset),
         .flush (flush),
         .push  (bank_push[i]),
         .din   (bank_din[i]),
         .ready (bank_ready[i]),
         .pop   (bank_pop[i]),
         .dout  (bank_dout[i]),
         .valid (bank_valid[i])
      );
   end

   // Issue slot i reads the bank at head plus i
   for (genvar i = 0; i < IW; i++)
   begin : g_issue
      logic [P_BANKS-1:0] bank_sel;

      assign bank_sel = head + P_BANKS'(i);
      assign {iq_ins[i], iq_pc[i], iq_exc[i]} = bank_dout[bank_sel];
      assign iq_valid[i] = bank_valid[bank_sel];
   end

   // A full window fits only if every bank has room
   assign fetch_ready = &bank_ready;

   // Configuration sanity
   initial
   begin
      if (P_IQ_DEPTH < P_FETCH_WIDTH)
         $fatal(1, "iq: bank depth below fetch width");
      if (P_ISSUE_WIDTH > P_FETCH_WIDTH)
         $fatal(1, "iq: issue width above fetch width");
   end

endmodule

/* id_latch.sv */
// Decode input register
// Pops the leading valid issue slots and holds them while decode stalls

`timescale 1ns/1ps

module id_latch
   import iq_pkg::*;
#(
   parameter int P_ISSUE_WIDTH = 1
)
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              flush,
   // From the queue
   input  logic  [(1<<P_ISSUE_WIDTH)-1:0]    iq_valid,
   input  insn_t [(1<<P_ISSUE_WIDTH)-1:0]    iq_ins,
   input  pc_t   [(1<<P_ISSUE_WIDTH)-1:0]    iq_pc,
   input  exc_t  [(1<<P_ISSUE_WIDTH)-1:0]    iq_exc,
   output logic  [P_ISSUE_WIDTH:0]           iq_pop_cnt,
   // Decode side
   input  logic                              dec_stall,
   output logic  [(1<<P_ISSUE_WIDTH)-1:0]    dec_valid,
   output insn_t [(1<<P_ISSUE_WIDTH)-1:0]    dec_ins,
   output pc_t   [(1<<P_ISSUE_WIDTH)-1:0]    dec_pc,
   output exc_t  [(1<<P_ISSUE_WIDTH)-1:0]    dec_exc
);

   localparam int IW = 1 << P_ISSUE_WIDTH;

   logic [IW-1:0]          lead_mask;
   logic [P_ISSUE_WIDTH:0] lead_cnt;

   // Leading valid prefix, empty under stall
   assign lead_mask[0] = iq_valid[0] & ~dec_stall;
   for (genvar i = 1; i < IW; i++)
   begin : g_lead
      assign lead_mask[i] = lead_mask[i-1] & iq_valid[i];
   end

   // Length of the prefix
   always_comb
   begin
      lead_cnt = '0;
      for (int i = 0; i < IW; i++)
         lead_cnt = lead_cnt + (P_ISSUE_WIDTH+1)'(lead_mask[i]);
   end

   // Queue drops what is taken here at the same edge
   assign iq_pop_cnt = lead_cnt;

   always_ff @(posedge clk)
   begin
      if (reset || flush)
         dec_valid <= '0;
      else if (!dec_stall)
         dec_valid <= lead_mask;
   end

   // Slot payload, held while stalled
   always_ff @(posedge clk)
   begin
      if (!dec_stall)
      begin
         dec_ins <= iq_ins;
         dec_pc  <= iq_pc;
         dec_exc <= iq_exc;
      end
   end

endmodule

/* iq_top.sv */
// Front-end instruction queue top level
// Banked queue feeding the decode input latch

`timescale 1ns/1ps

module iq_top
   import iq_pkg::*;
#(
   parameter int P_FETCH_WIDTH = 2,
   parameter int P_ISSUE_WIDTH = 1,
   parameter int P_IQ_DEPTH    = 2
)
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              flush,
   // Fetch window
   input  insn_t [(1<<P_FETCH_WIDTH)-1:0]    fetch_ins,
   input  pc_t   [(1<<P_FETCH_WIDTH)-1:0]    fetch_pc,
   input  exc_t  [(1<<P_FETCH_WIDTH)-1:0]    fetch_exc,
   input  logic  [P_FETCH_WIDTH:0]           fetch_cnt,
   output logic                              fetch_ready,
   // Decode
   input  logic                              dec_stall,
   output logic  [(1<<P_ISSUE_WIDTH)-1:0]    dec_valid,
   output insn_t [(1<<P_ISSUE_WIDTH)-1:0]    dec_ins,
   output pc_t   [(1<<P_ISSUE_WIDTH)-1:0]    dec_pc,
   output exc_t  [(1<<P_ISSUE_WIDTH)-1:0]    dec_exc
);

   localparam int IW = 1 << P_ISSUE_WIDTH;

   // Issue slots between queue and latch
   logic  [IW-1:0]          iq_valid;
   logic  [P_ISSUE_WIDTH:0] iq_pop_cnt;
   insn_t [IW-1:0]          iq_ins;
   pc_t   [IW-1:0]          iq_pc;
   exc_t  [IW-1:0]          iq_exc;

   iq
   #(
      .P_FETCH_WIDTH (P_FETCH_WIDTH),
      .P_ISSUE_WIDTH (P_ISSUE_WIDTH),
      .P_IQ_DEPTH    (P_IQ_DEPTH)
   )
   i_iq
   (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .fetch_ins   (fetch_ins),
      .fetch_pc    (fetch_pc),
      .fetch_exc   (fetch_exc),
      .fetch_cnt   (fetch_cnt),
      .fetch_ready (fetch_ready),
      .iq_valid    (iq_valid),
      .iq_pop_cnt  (iq_pop_cnt),
      .iq_ins      (iq_ins),
      .iq_pc       (iq_pc),
      .iq_exc      (iq_exc)
   );

   id_latch
   #(
      .P_ISSUE_WIDTH (P_ISSUE_WIDTH)
   )
   i_id_latch
   (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .iq_valid   (iq_valid),
      .iq_ins     (iq_ins),
      .iq_pc      (iq_pc),
      .iq_exc     (iq_exc),
      .iq_pop_cnt (iq_pop_cnt),
      .dec_stall  (dec_stall),
      .dec_valid  (dec_valid),
      .dec_ins    (dec_ins),
      .dec_pc     (dec_pc),
      .dec_exc    (dec_exc)
   );

endmodule

/* iq_top_checker.sv */
// Concurrent assertions for the instruction queue top level
// Ordering, integrity, reset, flush, stall hold, latency, overflow

`timescale 1ns/1ps

module iq_top_checker
   import iq_pkg::*;
#(
   parameter int  P_FETCH_WIDTH = 2,
   parameter int  P_ISSUE_WIDTH = 1,
   parameter pc_t RESET_BASE    = 32'h0000_1000,
   parameter pc_t FLUSH_BASE    = 32'h0000_8000
)
(
   input logic                               clk,
   input logic                               reset,
   input logic                               flush,
   input pc_t   [(1<<P_FETCH_WIDTH)-1:0]     fetch_pc,
   input logic  [P_FETCH_WIDTH:0]            fetch_cnt,
   input logic                               fetch_ready,
   input logic  [(1<<P_ISSUE_WIDTH)-1:0]     iq_valid,
   input logic                               dec_stall,
   input logic  [(1<<P_ISSUE_WIDTH)-1:0]     dec_valid,
   input insn_t [(1<<P_ISSUE_WIDTH)-1:0]     dec_ins,
   input pc_t   [(1<<P_ISSUE_WIDTH)-1:0]     dec_pc,
   input exc_t  [(1<<P_ISSUE_WIDTH)-1:0]     dec_exc
);

   localparam int FW = 1 << P_FETCH_WIDTH;
   localparam int IW = 1 << P_ISSUE_WIDTH;

   // Failed assertion tally, read by the testbench
   int unsigned fail_cnt = 0;

   // PC expected next in slot 0
   pc_t exp_pc;
   pc_t taken_bytes;
   // Oldest PC of the current fetch window
   pc_t oldest_pc;

   assign oldest_pc = fetch_pc[P_FETCH_WIDTH'(FW - fetch_cnt)];

   always_comb
   begin
      taken_bytes = '0;
      for (int i = 0; i < IW; i++)
         taken_bytes = taken_bytes + (dec_valid[i] ? 32'd4 : 32'd0);
   end

   // Decode consumes the slots on every unstalled cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         exp_pc <= RESET_BASE;
      else if (flush)
         exp_pc <= FLUSH_BASE;
      else if (!dec_stall)
         exp_pc <= exp_pc + taken_bytes;
   end

   // Program order in slot 0, restarts at the base after a flush
   a_order: assert property (@(posedge clk) disable iff (reset)
      (!dec_stall && !flush && dec_valid[0]) |-> dec_pc[0] == exp_pc)
      else begin fail_cnt++; $error("slot 0 PC out of order"); end

   // Valid slots form a prefix with consecutive PCs
   a_pair: assert property (@(posedge clk) disable iff (reset)
      dec_valid[1] |-> (dec_valid[0] && dec_pc[1] == dec_pc[0] + 32'd4))
      else begin fail_cnt++; $error("slot 1 not following slot 0"); end

   for (genvar i = 0; i < IW; i++)
   begin : g_slot
      // Payload matches its PC
      a_integrity: assert property (@(posedge clk) disable iff (reset)
         dec_valid[i] |-> (dec_ins[i] == ~dec_pc[i] && dec_exc[i] == dec_pc[i][3:2]))
         else begin fail_cnt++; $error("slot payload corrupted"); end

      // Held slot keeps its data
      a_hold: assert property (@(posedge clk) disable iff (reset)
         (dec_stall && !flush && dec_valid[i]) |=>
            (dec_valid[i] && $stable(dec_pc[i]) && $stable(dec_ins[i])
             && $stable(dec_exc[i])))
         else begin fail_cnt++; $error("slot changed under stall"); end
   end

   a_hold_valid: assert property (@(posedge clk) disable iff (reset)
      (dec_stall && !flush) |=> $stable(dec_valid))
      else begin fail_cnt++; $error("valid mask changed under stall"); end

   // Through reset and one cycle past it
   a_reset: assert property (@(posedge clk)
      reset |=> (dec_valid == '0 && fetch_ready))
      else begin fail_cnt++; $error("bad state after reset"); end

   a_flush: assert property (@(posedge clk) disable iff (reset)
      flush |=> (dec_valid == '0 && iq_valid == '0 && fetch_ready))
      else begin fail_cnt++; $error("state not cleared by flush"); end

   // Window into an empty queue reaches decode two edges later
   a_latency: assert property (@(posedge clk) disable iff (reset)
      (!flush && iq_valid == '0 && fetch_cnt >= 2) ##1 (!dec_stall && !flush) |=>
         (&dec_valid && dec_pc[0] == $past(oldest_pc, 2)))
      else begin fail_cnt++; $error("window latency wrong"); end

   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      !fetch_ready |-> fetch_cnt == '0)
      else begin fail_cnt++; $error("fetch pushed while not ready"); end

   // Two free decode cycles without fetch take one entry from every bank
   a_recover: assert property (@(posedge clk) disable iff (reset || flush)
      (!fetch_ready && !dec_stall) ##1 (!dec_stall && fetch_cnt == '0) |=> fetch_ready)
      else begin fail_cnt++; $error("fetch_ready stuck low"); end

endmodule

/* tb_iq_top.sv */
// Testbench for the instruction queue top level
// Clock, reset, LCG driven fetch windows and stalls, one flush, timeout

`timescale 1ns/1ps

module tb_iq_top;
   import iq_pkg::*;

   localparam int  FW         = 4;
   localparam int  IW         = 2;
   localparam int  RUN_CYCLES = 600;
   localparam int  MAX_CYCLES = 700;
   localparam int  FLUSH_AT   = 300;
   localparam pc_t BASE0      = 32'h0000_1000;
   localparam pc_t BASE1      = 32'h0000_8000;

   logic             clk = 1'b0;
   logic             reset;
   logic             flush;
   insn_t [FW-1:0]   fetch_ins;
   pc_t   [FW-1:0]   fetch_pc;
   exc_t  [FW-1:0]   fetch_exc;
   logic  [2:0]      fetch_cnt;
   logic             fetch_ready;
   logic             dec_stall;
   logic  [IW-1:0]   dec_valid;
   insn_t [IW-1:0]   dec_ins;
   pc_t   [IW-1:0]   dec_pc;
   exc_t  [IW-1:0]   dec_exc;

   int unsigned      tb_errors = 0;
   int unsigned      cycles = 0;
   logic [31:0]      rng = 32'h6ebe42fc;
   int unsigned      seq;
   pc_t              base;

   iq_top i_dut
   (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .fetch_ins   (fetch_ins),
      .fetch_pc    (fetch_pc),
      .fetch_exc   (fetch_exc),
      .fetch_cnt   (fetch_cnt),
      .fetch_ready (fetch_ready),
      .dec_stall   (dec_stall),
      .dec_valid   (dec_valid),
      .dec_ins     (dec_ins),
      .dec_pc      (dec_pc),
      .dec_exc     (dec_exc)
   );

   bind iq_top iq_top_checker
   #(
      .RESET_BASE (32'h0000_1000),
      .FLUSH_BASE (32'h0000_8000)
   )
   i_checker
   (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .fetch_pc    (fetch_pc),
      .fetch_cnt   (fetch_cnt),
      .fetch_ready (fetch_ready),
      .iq_valid    (iq_valid),
      .dec_stall   (dec_stall),
      .dec_valid   (dec_valid),
      .dec_ins     (dec_ins),
      .dec_pc      (dec_pc),
      .dec_exc     (dec_exc)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Packs cnt entries at the top of the window, oldest first
   task automatic drive_window(input int cnt);
      pc_t pc;
      fetch_ins = '0;
      fetch_pc  = '0;
      fetch_exc = '0;
      for (int j = 0; j < cnt; j++)
      begin
         pc = base + 32'(4 * (seq + j));
         fetch_pc[FW-cnt+j]  = pc;
         fetch_ins[FW-cnt+j] = ~pc;
         fetch_exc[FW-cnt+j] = exc_t'(seq + j);
      end
      fetch_cnt = 3'(cnt);
      seq = seq + cnt;
   endtask

   // Hard limit on the run length
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   initial
   begin
      int cnt;
      reset     = 1'b1;
      flush     = 1'b0;
      dec_stall = 1'b0;
      fetch_ins = '0;
      fetch_pc  = '0;
      fetch_exc = '0;
      fetch_cnt = '0;
      seq       = 0;
      base      = BASE0;

      repeat (4) @(posedge clk);
      #10;
      reset = 1'b0;

      // Idle state right after reset
      if (fetch_ready !== 1'b1)
      begin
         $display("[FAIL] %0t fetch_ready got %b expected 1", $time, fetch_ready);
         tb_errors++;
      end
      if (dec_valid !== '0)
      begin
         $display("[FAIL] %0t dec_valid got %b expected 00", $time, dec_valid);
         tb_errors++;
      end

      for (int c = 0; c < RUN_CYCLES; c++)
      begin
         rng = lcg_next(rng);
         if (c == FLUSH_AT)
         begin
            flush     = 1'b1;
            dec_stall = 1'b0;
            drive_window(0);
         end
         else
         begin
            if (c == FLUSH_AT + 1)
            begin
               // Numbering restarts behind the flush
               seq  = 0;
               base = BASE1;
            end
            flush = 1'b0;
            // Long stall run fills the queue
            if (c >= 150 && c < 180)
               dec_stall = 1'b1;
            else
               dec_stall = (rng[9:8] == 2'b00);
            cnt = int'(rng[23:16]) % 5;
            if (!fetch_ready)
               cnt = 0;
            // Decode runs and fetch idles right after the long stall
            if (c >= 180 && c < 182)
            begin
               dec_stall = 1'b0;
               cnt       = 0;
            end
            drive_window(cnt);
         end
         @(posedge clk);
         #10;
      end

      flush     = 1'b0;
      dec_stall = 1'b0;
      drive_window(0);
      repeat (10) @(posedge clk);

      $display("Errors: testbench %0d, assertions %0d",
               tb_errors, i_dut.i_checker.fail_cnt);
      if (tb_errors == 0 && i_dut.i_checker.fail_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* verilog.f */
iq_pkg.sv
fifo_fwft.sv
iq.sv
id_latch.sv
iq_top.sv
iq_top_checker.sv
tb_iq_top.sv
